//--- io_consts.svh
// shared width, depth, timing and scancode constants, included by every rtl and bench file
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// scancode byte width
`define KB_WIDTH 8

// receiver queue entries
`define KB_DEPTH 8

// clk200m cycles per half serial bit
`define SEG_DIV 4

// bits shifted per display frame
`define SEG_BITS 64

// idle cycles with seg_en high between frames
`define SEG_GAP 16

// equal samples needed before the ps2 clock is believed
`define FILT_LEN 4

// ps2 break prefix
`define PS2_BREAK 8'hF0

// ps2 extended prefix
`define PS2_EXT 8'hE0

// board led count
`define LED_WIDTH 8

`endif

//--- io_pkg.sv
// types shared by the keyboard and display block, imported by the rtl and the testbench
`include "io_consts.svh"

package io_pkg;

    // key history word
    // decoder writes bytes, byte 0 newest
    // serializer reads nibbles, nibble 7 shown on the leftmost digit
    typedef union packed {
        logic [3:0][`KB_WIDTH-1:0] bytes;
        logic [7:0][3:0]           nibbles;
    } hist_word_u;

    // ps2 frame receiver states
    // idle waits for the start bit
    // data takes eight bits lsb first
    // parity takes the odd parity bit
    // stop takes the stop bit and closes the frame
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

endpackage

//--- io_top.sv
// keyboard and display block top, joins the ps2 receiver, key decoder and display driver to pins
`include "io_consts.svh"

module io_top
    import io_pkg::*;
(
    input  logic                  clk200m,
    input  logic                  rst,
    input  logic                  ps2_clk,
    input  logic                  ps2_data,
    input  logic [1:0]            swt,
    output logic [`LED_WIDTH-1:0] leds,
    output logic                  seg_clk,
    output logic                  seg_clrn,
    output logic                  seg_dt,
    output logic                  seg_en
);

    // receiver to decoder
    logic [`KB_WIDTH-1:0]  kb_data;
    logic                  kb_ready;
    logic                  kb_rd;
    logic                  overflow;

    // decoder to display and leds
    hist_word_u            hist;
    logic [`LED_WIDTH-2:0] key_count;

    ps2_rx ps2_rx_i (
        .clk200m  (clk200m),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .kb_rd    (kb_rd),
        .kb_data  (kb_data),
        .kb_ready (kb_ready),
        .overflow (overflow)
    );

    // swt[0] freezes, swt[1] raw byte mode
    key_decoder key_decoder_i (
        .clk200m   (clk200m),
        .rst       (rst),
        .kb_data   (kb_data),
        .kb_ready  (kb_ready),
        .sw_hold   (swt[0]),
        .sw_raw    (swt[1]),
        .kb_rd     (kb_rd),
        .hist      (hist),
        .key_count (key_count)
    );

    seg_serializer seg_serializer_i (
        .clk200m  (clk200m),
        .rst      (rst),
        .hist     (hist),
        .seg_clk  (seg_clk),
        .seg_clrn (seg_clrn),
        .seg_dt   (seg_dt),
        .seg_en   (seg_en)
    );

    // top led shows the sticky overflow
    assign leds = {overflow, key_count};

endmodule

//--- key_decoder.sv
// scancode decoder, keeps the last four recorded bytes and a key press count for display
`include "io_consts.svh"

module key_decoder
    import io_pkg::*;
(
    input  logic                   clk200m,
    input  logic                   rst,
    input  logic [`KB_WIDTH-1:0]   kb_data,
    input  logic                   kb_ready,
    input  logic                   sw_hold,
    input  logic                   sw_raw,
    output logic                   kb_rd,
    output hist_word_u             hist,
    output logic [`LED_WIDTH-2:0]  key_count
);

    // byte class of the queue head
    logic is_break;
    logic is_ext;

    // set by F0 until the released key code has gone by
    logic break_armed;

    // head byte goes into the history
    logic record;
    logic update;

    // pop whenever a byte waits, one per cycle at most
    assign kb_rd = kb_ready;

    assign is_break = (kb_data == `PS2_BREAK);
    assign is_ext   = (kb_data == `PS2_EXT);

    // raw mode takes everything
    // normal mode takes only make codes
    always_comb begin
        if (sw_raw) begin
            record = 1'b1;
        end else begin
            record = ~is_break & ~is_ext & ~break_armed;
        end
    end

    // hold freezes history and count but not the pop
    assign update = kb_rd & record & ~sw_hold;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            break_armed <= 1'b0;
        end else if (kb_rd) begin
            // next byte after F0 clears the flag
            if (is_break) begin
                break_armed <= 1'b1;
            end else if (break_armed) begin
                break_armed <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            hist      <= '0;
            key_count <= '0;
        end else if (update) begin
            // newest byte enters at byte 0, oldest falls off the top
            hist.bytes <= {hist.bytes[2:0], kb_data};
            // seven bit count wraps at 128
            key_count  <= key_count + 1'b1;
        end
    end

endmodule

//--- ps2_rx.sv
// ps2 keyboard receiver, frames scancode bytes and queues them for the key decoder
`include "io_consts.svh"

module ps2_rx
    import io_pkg::*;
(
    input  logic                 clk200m,
    input  logic                 rst,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    input  logic                 kb_rd,
    output logic [`KB_WIDTH-1:0] kb_data,
    output logic                 kb_ready,
    output logic                 overflow
);

    localparam int PTR_W = $clog2(`KB_DEPTH);

    // two flop synchronizers, lines idle high
    logic ps2_clk_s1;
    logic ps2_clk_s2;
    logic ps2_data_s1;
    logic ps2_data_s2;

    // clock glitch filter
    logic [`FILT_LEN-1:0] clk_shift;
    logic                 clk_filt;
    logic                 clk_filt_d;
    logic                 clk_fall;

    // frame machine
    rx_state_e            rx_state;
    logic [2:0]           bit_cnt;
    logic [`KB_WIDTH-1:0] shift_reg;
    logic                 start_ok;
    logic                 parity_ok;
    logic                 frame_done;
    logic                 frame_good;
    logic                 push;

    // circular queue, pointers carry a wrap bit
    logic [`KB_WIDTH-1:0] mem [`KB_DEPTH];
    logic [PTR_W:0]       wr_ptr;
    logic [PTR_W:0]       rd_ptr;
    logic                 full;
    logic                 pop;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            ps2_clk_s1  <= 1'b1;
            ps2_clk_s2  <= 1'b1;
            ps2_data_s1 <= 1'b1;
            ps2_data_s2 <= 1'b1;
            clk_shift   <= '1;
            clk_filt    <= 1'b1;
            clk_filt_d  <= 1'b1;
        end else begin
            ps2_clk_s1  <= ps2_clk;
            ps2_clk_s2  <= ps2_clk_s1;
            ps2_data_s1 <= ps2_data;
            ps2_data_s2 <= ps2_data_s1;
            clk_shift   <= {clk_shift[`FILT_LEN-2:0], ps2_clk_s2};
            // filtered level moves only on a full run of equal samples
            if (&clk_shift) begin
                clk_filt <= 1'b1;
            end else if (~|clk_shift) begin
                clk_filt <= 1'b0;
            end
            clk_filt_d <= clk_filt;
        end
    end

    // one cycle pulse per clean falling edge
    assign clk_fall = clk_filt_d & ~clk_filt;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            rx_state   <= RX_IDLE;
            bit_cnt    <= '0;
            start_ok   <= 1'b0;
            parity_ok  <= 1'b0;
            frame_done <= 1'b0;
            frame_good <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (clk_fall) begin
                case (rx_state)
                    RX_IDLE: begin
                        // start bit must be low
                        start_ok <= ~ps2_data_s2;
                        bit_cnt  <= '0;
                        rx_state <= RX_DATA;
                    end
                    RX_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            rx_state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: begin
                        // odd parity over data plus parity bit
                        parity_ok <= ^{shift_reg, ps2_data_s2};
                        rx_state  <= RX_STOP;
                    end
                    default: begin
                        // stop bit high closes a good frame
                        frame_good <= start_ok & parity_ok & ps2_data_s2;
                        frame_done <= 1'b1;
                        rx_state   <= RX_IDLE;
                    end
                endcase
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk200m) begin
        if (clk_fall && rx_state == RX_DATA) begin
            shift_reg <= {ps2_data_s2, shift_reg[`KB_WIDTH-1:1]};
        end
    end

    // queue write one cycle after the stop bit
    assign push = frame_done & frame_good;
    assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                  (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign kb_ready = (wr_ptr != rd_ptr);
    assign pop = kb_rd & kb_ready;
    assign kb_data = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk200m) begin
        if (push && !full) begin
            mem[wr_ptr[PTR_W-1:0]] <= shift_reg;
        end
    end

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                // full queue drops the byte, flag sticks until reset
                if (full) begin
                    overflow <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run tb_io_top with Verilator, non-zero exit on any failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_io_top -o sim_tb -f tb.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed"
    exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit "$status"
fi

exit 0

//--- seg_serializer.sv
// serial driver for the 8 digit 7-segment chain, shows the key history as hex digits
`include "io_consts.svh"

module seg_serializer
    import io_pkg::*;
(
    input  logic       clk200m,
    input  logic       rst,
    input  hist_word_u hist,
    output logic       seg_clk,
    output logic       seg_clrn,
    output logic       seg_dt,
    output logic       seg_en
);

    localparam int DIV_W = $clog2(`SEG_DIV);
    localparam int BIT_W = $clog2(`SEG_BITS + 1);
    localparam int GAP_W = $clog2(`SEG_GAP);

    // half bit prescaler
    logic [DIV_W-1:0]     div_cnt;
    logic                 tick;

    // frame sequencing
    logic [BIT_W-1:0]     bit_cnt;
    logic [GAP_W-1:0]     gap_cnt;
    logic                 frame_start;

    // segment patterns, digit 7 in the top byte
    logic [`SEG_BITS-1:0] seg_frame;
    logic [`SEG_BITS-1:0] shift_reg;

    // hex glyph, active low, dp g f e d c b a, dp dark
    function automatic logic [7:0] hex_to_seg(input logic [3:0] nib);
        logic [7:0] seg;
        case (nib)
            4'h0: seg = 8'hC0;
            4'h1: seg = 8'hF9;
            4'h2: seg = 8'hA4;
            4'h3: seg = 8'hB0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hF8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'hA: seg = 8'h88;
            4'hB: seg = 8'h83;
            4'hC: seg = 8'hC6;
            4'hD: seg = 8'hA1;
            4'hE: seg = 8'h86;
            default: seg = 8'h8E;
        endcase
        return seg;
    endfunction

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            seg_frame[i*8 +: 8] = hex_to_seg(hist.nibbles[i]);
        end
    end

    // gap over, sample hist and begin shifting
    assign frame_start = seg_en && (gap_cnt == GAP_W'(`SEG_GAP - 1));
    assign tick = (div_cnt == DIV_W'(`SEG_DIV - 1));

    // msb goes out first
    assign seg_dt = shift_reg[`SEG_BITS-1];

    always_ff @(posedge clk200m) begin
        if (frame_start) begin
            shift_reg <= seg_frame;
        end else if (!seg_en && tick && seg_clk && bit_cnt != BIT_W'(`SEG_BITS)) begin
            // next bit set up as the clock drops
            shift_reg <= {shift_reg[`SEG_BITS-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            div_cnt  <= '0;
            bit_cnt  <= '0;
            gap_cnt  <= '0;
            seg_clk  <= 1'b0;
            seg_en   <= 1'b1;
            seg_clrn <= 1'b0;
        end else if (seg_en) begin
            // latch interval, count out the gap
            if (frame_start) begin
                seg_en  <= 1'b0;
                gap_cnt <= '0;
                div_cnt <= '0;
                bit_cnt <= '0;
            end else begin
                gap_cnt <= gap_cnt + 1'b1;
            end
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                if (!seg_clk) begin
                    // rising edge, display samples seg_dt
                    seg_clk <= 1'b1;
                    bit_cnt <= bit_cnt + 1'b1;
                end else begin
                    seg_clk <= 1'b0;
                    // all bits clocked in, raise seg_en to latch
                    if (bit_cnt == BIT_W'(`SEG_BITS)) begin
                        seg_en   <= 1'b1;
                        // chain cleared through the first frame only
                        seg_clrn <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- tb.f
+incdir+.
io_pkg.sv
ps2_rx.sv
key_decoder.sv
seg_serializer.sv
io_top.sv
tb_io_top.sv

//--- tb_io_top.sv
// testbench for io_top, drives ps2 frames and checks the leds and the serial display stream
`include "io_consts.svh"

module tb_io_top
    import io_pkg::*;
();

    // ps2 half bit in clk200m cycles, full bit is 40
    localparam int PS2_HALF   = 20;
    localparam int WAIT_LIMIT = 2000;
    localparam int BURST_LEN  = 12;

    logic                  clk200m;
    logic                  rst;
    logic                  ps2_clk;
    logic                  ps2_data;
    logic [1:0]            swt;
    logic [`LED_WIDTH-1:0] leds;
    logic                  seg_clk;
    logic                  seg_clrn;
    logic                  seg_dt;
    logic                  seg_en;

    // reference decoder state
    logic [31:0] ref_hist;
    logic [6:0]  ref_count;
    logic        ref_break;
    logic [31:0] rng;

    // display capture
    logic        seg_clk_q;
    logic        seg_en_q;
    logic [63:0] cap_bits;
    logic [63:0] exp_frame;
    int          edge_cnt;
    int          frames_done;
    int          check_req;
    int          check_done;

    // standard hex glyphs, active low, dp g f e d c b a
    logic [7:0] glyph_tab [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    io_top dut_i (
        .clk200m  (clk200m),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .swt      (swt),
        .leds     (leds),
        .seg_clk  (seg_clk),
        .seg_clrn (seg_clrn),
        .seg_dt   (seg_dt),
        .seg_en   (seg_en)
    );

    initial begin
        clk200m = 1'b0;
        forever #2 clk200m = ~clk200m;
    end

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("CHECK FAILED at time %0t: %s got 0x%0h expected 0x%0h",
                 $time, name, got, want);
        stop_with_failure();
    endtask

    task automatic wait_failed(input string what);
        rx_state_e st;
        st = dut_i.ps2_rx_i.rx_state;
        $display("timeout while waiting for %s, receiver in %s", what, st.name());
        stop_with_failure();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // digit 7 leads, so nibble 7 lands in the top byte
    function automatic logic [63:0] frame_of(input logic [31:0] h);
        logic [63:0] f;
        f = '0;
        for (int d = 7; d >= 0; d--) begin
            f = {f[55:0], glyph_tab[h[d*4 +: 4]]};
        end
        return f;
    endfunction

    // random make code, prefixes never picked
    task automatic random_code(output logic [7:0] code);
        rng  = xorshift32(rng);
        code = rng[7:0];
        while (code == `PS2_BREAK || code == `PS2_EXT) begin
            rng  = xorshift32(rng);
            code = rng[7:0];
        end
    endtask

    // start, eight data lsb first, odd parity, stop
    // data moves while the ps2 clock is high
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data <= bits[i];
            repeat (PS2_HALF) @(posedge clk200m);
            ps2_clk <= 1'b0;
            repeat (PS2_HALF) @(posedge clk200m);
            ps2_clk <= 1'b1;
        end
        // idle high, long enough for the decoder update
        repeat (PS2_HALF) @(posedge clk200m);
    endtask

    // decoder rules, break flag tracked in every mode
    task automatic model_byte(input logic [7:0] b);
        logic rec;
        rec = swt[1] ? 1'b1 : (b != `PS2_BREAK && b != `PS2_EXT && !ref_break);
        if (b == `PS2_BREAK) begin
            ref_break = 1'b1;
        end else if (ref_break) begin
            ref_break = 1'b0;
        end
        if (rec && !swt[0]) begin
            ref_hist  = {ref_hist[23:0], b};
            ref_count = ref_count + 7'd1;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        send_frame(b, 1'b0);
        model_byte(b);
    endtask

    task automatic check_leds();
        assert (leds == {1'b0, ref_count})
            else report_mismatch("leds", 64'(leds), 64'({1'b0, ref_count}));
    endtask

    // optionally let the running frame finish, then have the next one compared
    task automatic check_display(input logic sync_frame);
        int cnt;
        int start;
        int target;
        cnt = 0;
        if (sync_frame) begin
            start = frames_done;
            while (frames_done == start && cnt < WAIT_LIMIT) begin
                @(posedge clk200m);
                cnt++;
            end
            if (frames_done == start) begin
                wait_failed("end of the running display frame");
            end
        end
        target = check_req + 1;
        exp_frame <= frame_of(ref_hist);
        check_req <= target;
        cnt = 0;
        while (check_done != target && cnt < WAIT_LIMIT) begin
            @(posedge clk200m);
            cnt++;
        end
        if (check_done != target) begin
            wait_failed("the display frame compare");
        end
    endtask

    // shift in on seg_clk rising, judge the frame on seg_en rising
    always @(posedge clk200m) begin
        seg_clk_q <= seg_clk;
        seg_en_q  <= seg_en;
        if (rst) begin
            edge_cnt    <= 0;
            frames_done <= 0;
            check_done  <= 0;
        end else begin
            if (!seg_en && seg_clk && !seg_clk_q) begin
                cap_bits <= {cap_bits[62:0], seg_dt};
                edge_cnt <= edge_cnt + 1;
                // chain held clear in the first frame only
                if (edge_cnt == 0) begin
                    assert (seg_clrn == (frames_done != 0))
                        else report_mismatch("seg_clrn", 64'(seg_clrn),
                                             64'(frames_done != 0));
                end
            end
            if (seg_en && !seg_en_q) begin
                assert (edge_cnt == `SEG_BITS)
                    else report_mismatch("seg_clk rising edges", 64'(edge_cnt),
                                         64'(`SEG_BITS));
                if (check_done != check_req) begin
                    assert (cap_bits == exp_frame)
                        else report_mismatch("display frame", cap_bits, exp_frame);
                    check_done <= check_done + 1;
                end
                edge_cnt    <= 0;
                frames_done <= frames_done + 1;
            end
        end
    end

    // serial data settles only while the display clock is low
    assert property (@(posedge clk200m) disable iff (rst) $changed(seg_dt) |-> !seg_clk)
        else report_mismatch("seg_clk at seg_dt change", 64'(seg_clk), 64'(0));

    // overflow led is sticky
    assert property (@(posedge clk200m) disable iff (rst) !$fell(leds[7]))
        else report_mismatch("leds[7]", 64'(leds[7]), 64'(1));

    initial begin
        logic [7:0] code;
        rst       = 1'b1;
        ps2_clk   = 1'b1;
        ps2_data  = 1'b1;
        swt       = 2'b00;
        ref_hist  = '0;
        ref_count = '0;
        ref_break = 1'b0;
        rng       = 32'd68;
        exp_frame = '0;
        check_req = 0;
        repeat (10) @(posedge clk200m);
        rst <= 1'b0;
        @(posedge clk200m);

        // reset values and the cleared first frame
        assert (leds == '0) else report_mismatch("leds", 64'(leds), 64'(0));
        assert (seg_clk == 1'b0) else report_mismatch("seg_clk", 64'(seg_clk), 64'(0));
        check_display(1'b0);

        // normal mode, make then break of the same key, one extended prefix
        for (int i = 0; i < 6; i++) begin
            random_code(code);
            if (i == 3) begin
                send_byte(`PS2_EXT);
            end
            send_byte(code);
            send_byte(`PS2_BREAK);
            send_byte(code);
        end
        check_leds();
        check_display(1'b1);

        // raw mode keeps the prefixes
        swt <= 2'b10;
        @(posedge clk200m);
        random_code(code);
        send_byte(code);
        send_byte(`PS2_BREAK);
        send_byte(code);
        check_leds();
        check_display(1'b1);

        // hold freezes, but the break flag still arms
        swt <= 2'b01;
        @(posedge clk200m);
        random_code(code);
        send_byte(code);
        send_byte(`PS2_BREAK);
        check_leds();
        check_display(1'b1);
        swt <= 2'b00;
        @(posedge clk200m);
        send_byte(code);
        random_code(code);
        send_byte(code);
        check_leds();
        check_display(1'b1);

        // parity error drops the byte, next good one lands
        random_code(code);
        send_frame(code, 1'b1);
        check_leds();
        check_display(1'b1);
        send_byte(code);
        check_leds();
        check_display(1'b1);

        // back to back burst, decoder drains faster than the pins fill
        repeat (BURST_LEN) begin
            random_code(code);
            send_byte(code);
        end
        assert (leds[7] == 1'b0) else report_mismatch("leds[7]", 64'(leds[7]), 64'(0));
        check_leds();
        check_display(1'b1);

        $display("Finished with no errors");
        $finish;
    end

endmodule
